//--- all.f
uart_cfg_pkg.sv
uart_cmd_pkg.sv
uart_frame_if.sv
baud_timer.sv
frame_tx.sv
frame_rx.sv
uart_cmd_fsm.sv
uart_cmd_master.sv
tb_clock_gen.sv
tb_uart_cmd_master.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_uart_cmd_master
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_uart_cmd_master.sv
`timescale 1ns/1ps

module tb_uart_cmd_master;

  localparam int CLKS_PER_BIT = 8;
  localparam int GAP_BITS = 2;
  localparam int HALF_BIT = CLKS_PER_BIT / 2;
  localparam int RESET_CYCLES = 16;
  localparam int N_WRITES = 15;
  localparam int N_READS = 15;
  localparam int N_PERR = 3;
  localparam int N_GLITCH = 2;
  localparam logic [31:0] SEED = 32'h3c04ca3c;

  // About 40 commands of up to 60 bit times each, plus reset and drain.
  localparam int N_CMDS_BUDGET = 40;
  localparam int BITS_PER_CMD = 60;
  localparam int TIMEOUT_CYCLES = N_CMDS_BUDGET * BITS_PER_CMD * CLKS_PER_BIT + 800;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        tx;
  logic        cmd_rdy;
  logic [7:0]  read_data;
  logic        read_vld;
  logic        parity_err;

  string test_name = "reset";
  int    cycles = 0;
  int    cmds_accepted = 0;
  int    reads_expected = 0;
  int    frames_seen = 0;
  int    reads_seen = 0;
  logic  read_vld_q = 1'b0;
  logic  reply_bad_par = 1'b0;
  logic  reply_glitch = 1'b0;

  // Expected results from the stimulus and frames decoded by the slave.
  logic [7:0] exp_frames[$];
  logic [7:0] exp_reads[$];
  logic       exp_perrs[$];
  logic [7:0] got_frames[$];
  logic       got_pars[$];
  logic       got_stops[$];

  tb_clock_gen #(
    .PERIOD_NS(20)
  ) tb_clock_gen_i (
    .clk (clk)
  );

  uart_cmd_master #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .GAP_BITS    (GAP_BITS)
  ) uart_cmd_master_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .rx         (rx),
    .tx         (tx),
    .cmd_rdy    (cmd_rdy),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .parity_err (parity_err)
  );

  // Register contents the remote slave returns for an address.
  function automatic logic [7:0] ref_reply(input logic [6:0] addr);
    logic [7:0] prod;
    prod = 8'({1'b0, addr} * 8'd3);
    return prod ^ 8'h5A;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
    $display("TEST FAILED");
    $fatal(1, "Mismatch in %s.", name);
  endtask

  task automatic report_failure(input string what);
    $display("Failure in %s: %s", test_name, what);
    $display("TEST FAILED");
    $fatal(1, "%s", what);
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("TEST FAILED");
      $fatal(1, "Timeout after %0d cycles during %s.", cycles, test_name);
    end
  end

  // Slave side. Bits are sampled on the falling edge, away from tx updates.
  task automatic decode_frame(output logic [7:0] data, output logic par,
                              output logic stop);
    @(negedge clk);
    while (tx !== 1'b0)
      @(negedge clk);
    repeat (HALF_BIT) @(negedge clk);
    for (int i = 0; i < 8; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop = tx;
  endtask

  task automatic send_reply(input logic [7:0] data, input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 11; i++)
    begin
      rx <= bits[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  // Low pulse of two cycles is well under half a bit.
  task automatic drive_glitch();
    @(posedge clk);
    rx <= 1'b0;
    repeat (2) @(posedge clk);
    rx <= 1'b1;
    repeat (2 * CLKS_PER_BIT) @(posedge clk);
  endtask

  initial
  begin : slave
    logic [7:0] data;
    logic       par;
    logic       stop;
    logic [7:0] hi_byte;
    logic       is_second;
    int         delay_bits;
    is_second = 1'b0;
    hi_byte = 8'h00;
    wait (rst_n === 1'b1);
    forever
    begin
      decode_frame(data, par, stop);
      got_frames.push_back(data);
      got_pars.push_back(par);
      got_stops.push_back(stop);
      if (is_second && !hi_byte[7])
      begin
        delay_bits = int'($urandom_range(20, 0));
        // Wait past the end of the stop bit so the receiver is armed.
        repeat (CLKS_PER_BIT + delay_bits * CLKS_PER_BIT) @(posedge clk);
        if (reply_glitch)
          drive_glitch();
        send_reply(ref_reply(hi_byte[6:0]), reply_bad_par);
      end
      if (!is_second)
        hi_byte = data;
      is_second = !is_second;
    end
  end

  always @(negedge clk)
  begin : compare
    logic [7:0] b;
    logic       par;
    logic       stop;
    logic [7:0] exp_b;
    logic [7:0] exp_d;
    logic       exp_p;
    if (got_frames.size() > 0)
    begin
      b = got_frames.pop_front();
      par = got_pars.pop_front();
      stop = got_stops.pop_front();
      frames_seen = frames_seen + 1;
      assert (exp_frames.size() > 0)
      else report_failure("the slave decoded a frame that no command asked for.");
      exp_b = exp_frames.pop_front();
      assert (b == exp_b)
      else report_mismatch({test_name, " frame byte"}, 32'(exp_b), 32'(b));
      assert (par == ~^exp_b)
      else report_mismatch({test_name, " frame parity"}, 32'(~^exp_b), 32'(par));
      assert (stop == 1'b1)
      else report_mismatch({test_name, " stop bit"}, 32'd1, 32'(stop));
    end
    if (read_vld)
    begin
      reads_seen = reads_seen + 1;
      assert (!read_vld_q)
      else report_failure("read_vld stayed high for more than one cycle.");
      assert (exp_reads.size() > 0)
      else report_failure("read_vld pulsed with no read pending.");
      exp_d = exp_reads.pop_front();
      exp_p = exp_perrs.pop_front();
      assert (read_data == exp_d)
      else report_mismatch({test_name, " read_data"}, 32'(exp_d), 32'(read_data));
      assert (parity_err == exp_p)
      else report_mismatch({test_name, " parity_err"}, 32'(exp_p), 32'(parity_err));
    end
    read_vld_q = read_vld;
  end

  task automatic issue_cmd(input logic [15:0] cmd, input logic extra_pulse);
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    exp_frames.push_back(cmd[15:8]);
    exp_frames.push_back(cmd[7:0]);
    if (!cmd[15])
    begin
      exp_reads.push_back(ref_reply(cmd[14:8]));
      exp_perrs.push_back(reply_bad_par);
      reads_expected = reads_expected + 1;
    end
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    cmds_accepted = cmds_accepted + 1;
    @(negedge clk);
    assert (cmd_rdy == 1'b0)
    else report_failure("cmd_rdy did not drop after an accepted command.");
    if (extra_pulse)
    begin
      // This strobe lands mid-frame and must be dropped.
      repeat (3 * CLKS_PER_BIT) @(negedge clk);
      assert (cmd_rdy == 1'b0)
      else report_failure("cmd_rdy was high in the middle of a frame.");
      @(posedge clk);
      cmd_in  <= ~cmd;
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
    while (!cmd_rdy)
      @(negedge clk);
    repeat (2) @(negedge clk);
    assert (frames_seen == 2 * cmds_accepted)
    else report_mismatch({test_name, " frame count"}, 32'(2 * cmds_accepted),
                         32'(frames_seen));
    assert (reads_seen == reads_expected)
    else report_mismatch({test_name, " read count"}, 32'(reads_expected), 32'(reads_seen));
  endtask

  initial
  begin : stimulus
    logic [14:0] r;
    cmd_in  = 16'h0000;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    rst_n   = 1'b0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "idle";
    repeat (20)
    begin
      @(negedge clk);
      assert (tx === 1'b1)
      else report_mismatch({test_name, " tx"}, 32'd1, 32'(tx));
      assert (cmd_rdy === 1'b1)
      else report_mismatch({test_name, " cmd_rdy"}, 32'd1, 32'(cmd_rdy));
    end

    test_name = "write";
    for (int i = 0; i < N_WRITES; i++)
    begin
      r = 15'($urandom);
      issue_cmd({1'b1, r}, i == 5);
    end

    test_name = "read";
    for (int i = 0; i < N_READS; i++)
    begin
      r = 15'($urandom);
      issue_cmd({1'b0, r}, i == 7);
    end

    test_name = "read_bad_parity";
    reply_bad_par = 1'b1;
    for (int i = 0; i < N_PERR; i++)
    begin
      r = 15'($urandom);
      issue_cmd({1'b0, r}, 1'b0);
    end
    reply_bad_par = 1'b0;

    test_name = "rx_glitch";
    reply_glitch = 1'b1;
    for (int i = 0; i < N_GLITCH; i++)
    begin
      r = 15'($urandom);
      issue_cmd({1'b0, r}, 1'b0);
    end
    reply_glitch = 1'b0;

    test_name = "drain";
    repeat (4 * CLKS_PER_BIT) @(negedge clk);
    if (exp_frames.size() == 0 && exp_reads.size() == 0 &&
        frames_seen == 2 * cmds_accepted && reads_seen == reads_expected)
    begin
      $display("TEST OK");
      $finish;
    end
    else
    begin
      $display("Results left unmatched at the end of the run.");
      $display("TEST FAILED");
      $fatal(1, "Unmatched frames or reads at the end.");
    end
  end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- uart_cmd_master.sv
`timescale 1ns/1ps

module uart_cmd_master #(
  parameter int CLKS_PER_BIT = uart_cfg_pkg::CLKS_PER_BIT_DEF,
  parameter int GAP_BITS     = uart_cfg_pkg::GAP_BITS_DEF
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0] cmd_in,
  input  logic                               cmd_vld,
  input  logic                               rx,
  output logic                               tx,
  output logic                               cmd_rdy,
  output logic [uart_cfg_pkg::DATA_BITS-1:0] read_data,
  output logic                               read_vld,
  output logic                               parity_err
);

  logic tx_bit_tick;

  uart_frame_if fif ();

  frame_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) frame_tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .fif      (fif.txp),
    .tx       (tx),
    .bit_tick (tx_bit_tick)
  );

  frame_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) frame_rx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .fif   (fif.rxp),
    .rx    (rx)
  );

  // The gap between command frames is counted in transmit bit times.
  uart_cmd_fsm #(
    .GAP_BITS(GAP_BITS)
  ) uart_cmd_fsm_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .fif        (fif.ctrl),
    .gap_tick   (tx_bit_tick),
    .cmd_rdy    (cmd_rdy),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .parity_err (parity_err)
  );

endmodule

//--- uart_cmd_fsm.sv
`timescale 1ns/1ps

module uart_cmd_fsm #(
  parameter int GAP_BITS = uart_cfg_pkg::GAP_BITS_DEF
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                cmd_vld,
  uart_frame_if.ctrl                          fif,
  input  logic                                gap_tick,
  output logic                                cmd_rdy,
  output logic [uart_cfg_pkg::DATA_BITS-1:0]  read_data,
  output logic                                read_vld,
  output logic                                parity_err
);

  localparam int CW = uart_cmd_pkg::CMD_WIDTH;
  localparam int DW = uart_cfg_pkg::DATA_BITS;
  localparam int GCNT_W = $clog2(GAP_BITS + 1);
  localparam logic [GCNT_W-1:0] GCNT_LAST = GCNT_W'(GAP_BITS - 1);

  uart_cmd_pkg::cmd_state_e state;

  logic [CW-1:0]     cmd_q;
  logic [GCNT_W-1:0] gap_cnt;
  logic              accept;
  logic              launch;
  logic              start_q;
  logic              gap_done;

  assign cmd_rdy = (state == uart_cmd_pkg::ST_IDLE) || (state == uart_cmd_pkg::ST_DONE);
  assign accept = cmd_rdy && cmd_vld;

  // Low frame starts on the very tick that ends the gap.
  assign gap_done = (state == uart_cmd_pkg::ST_GAP) && gap_tick && (gap_cnt == GCNT_LAST);

  assign fif.tx_start = start_q || gap_done;
  assign fif.tx_byte = (state == uart_cmd_pkg::ST_SEND_HI) ? cmd_q[CW-1 -: DW] : cmd_q[DW-1:0];
  assign fif.rx_arm = (state == uart_cmd_pkg::ST_WAIT_RD);

  assign read_vld = (state == uart_cmd_pkg::ST_DONE);

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= uart_cmd_pkg::ST_IDLE;
      gap_cnt    <= '0;
      launch     <= 1'b0;
      start_q    <= 1'b0;
      read_data  <= '0;
      parity_err <= 1'b0;
    end
    else
    begin
      // High frame goes out two cycles after the host strobe.
      launch  <= accept;
      start_q <= launch;

      case (state)
        uart_cmd_pkg::ST_IDLE,
        uart_cmd_pkg::ST_DONE:
        begin
          if (cmd_vld)
            state <= uart_cmd_pkg::ST_SEND_HI;
          else
            state <= uart_cmd_pkg::ST_IDLE;
        end
        uart_cmd_pkg::ST_SEND_HI:
        begin
          if (fif.tx_done)
          begin
            state   <= uart_cmd_pkg::ST_GAP;
            gap_cnt <= '0;
          end
        end
        uart_cmd_pkg::ST_GAP:
        begin
          if (gap_done)
            state <= uart_cmd_pkg::ST_SEND_LO;
          else if (gap_tick)
            gap_cnt <= gap_cnt + 1'b1;
        end
        uart_cmd_pkg::ST_SEND_LO:
        begin
          if (fif.tx_done)
          begin
            if (cmd_q[uart_cmd_pkg::WRITE_BIT])
              state <= uart_cmd_pkg::ST_IDLE;
            else
              state <= uart_cmd_pkg::ST_WAIT_RD;
          end
        end
        uart_cmd_pkg::ST_WAIT_RD:
        begin
          // A lost reply holds the master here until reset.
          if (fif.rx_done)
          begin
            state      <= uart_cmd_pkg::ST_DONE;
            read_data  <= fif.rx_byte;
            parity_err <= fif.rx_perr;
          end
        end
        default:
        begin
          state <= uart_cmd_pkg::ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- frame_rx.sv
`timescale 1ns/1ps

module frame_rx #(
  parameter int CLKS_PER_BIT = uart_cfg_pkg::CLKS_PER_BIT_DEF
) (
  input  logic      clk,
  input  logic      rst_n,
  uart_frame_if.rxp fif,
  input  logic      rx
);

  localparam int NBITS = uart_cfg_pkg::FRAME_BITS;
  localparam int DBITS = uart_cfg_pkg::DATA_BITS;
  localparam int BCNT_W = $clog2(NBITS);
  localparam logic [BCNT_W-1:0] BCNT_PAR = BCNT_W'(DBITS + 1);
  localparam logic [BCNT_W-1:0] BCNT_STOP = BCNT_W'(NBITS - 1);

  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic              fall;
  logic              start;
  logic              busy;
  logic [BCNT_W-1:0] bit_cnt;
  logic [DBITS-1:0]  shift;
  logic              par_bit;
  logic              mid_tick;
  logic              stop_mid;

  baud_timer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) baud_timer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (busy),
    .clear    (start),
    .bit_tick (),
    .mid_tick (mid_tick)
  );

  // Two-flop synchronizer plus one more stage for the edge detect.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;
  assign start = !busy && fif.rx_arm && fall;
  assign stop_mid = busy && mid_tick && (bit_cnt == BCNT_STOP);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
    end
    else if (start)
    begin
      busy    <= 1'b1;
      bit_cnt <= '0;
    end
    else if (busy && mid_tick)
    begin
      // A high line at mid start bit means the edge was a glitch.
      if (bit_cnt == '0 && rx_sync)
        busy <= 1'b0;
      else if (bit_cnt == BCNT_STOP)
        busy <= 1'b0;
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (busy && mid_tick)
    begin
      if (bit_cnt != '0 && bit_cnt < BCNT_PAR)
        shift <= {rx_sync, shift[DBITS-1:1]};
      if (bit_cnt == BCNT_PAR)
        par_bit <= rx_sync;
    end
  end

  assign fif.rx_byte = shift;
  assign fif.rx_done = stop_mid;
  // Odd parity, so the expected bit is the inverted XOR of the data.
  assign fif.rx_perr = (par_bit != ~^shift);

endmodule

//--- frame_tx.sv
`timescale 1ns/1ps

module frame_tx #(
  parameter int CLKS_PER_BIT = uart_cfg_pkg::CLKS_PER_BIT_DEF
) (
  input  logic             clk,
  input  logic             rst_n,
  uart_frame_if.txp        fif,
  output logic             tx,
  output logic             bit_tick
);

  localparam int NBITS = uart_cfg_pkg::FRAME_BITS;
  localparam int BCNT_W = $clog2(NBITS);
  localparam logic [BCNT_W-1:0] BCNT_LAST = BCNT_W'(NBITS - 1);

  logic [NBITS-1:0]  sreg;
  logic [BCNT_W-1:0] bit_cnt;
  logic              busy;
  logic              last_bit;

  // Free running so the controller can time the inter-frame gap on it.
  baud_timer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) baud_timer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (1'b1),
    .clear    (fif.tx_start),
    .bit_tick (bit_tick),
    .mid_tick ()
  );

  assign last_bit = (bit_cnt == BCNT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sreg    <= '1;
      bit_cnt <= '0;
      busy    <= 1'b0;
    end
    else if (fif.tx_start)
    begin
      // Stop, odd parity, data, start. LSB goes out first.
      sreg    <= {1'b1, ~^fif.tx_byte, fif.tx_byte, 1'b0};
      bit_cnt <= '0;
      busy    <= 1'b1;
    end
    else if (busy && bit_tick)
    begin
      sreg <= {1'b1, sreg[NBITS-1:1]};
      if (last_bit)
        busy <= 1'b0;
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Line is the low end of the shift register, idling high.
  assign tx = sreg[0];

  assign fif.tx_done = busy && bit_tick && last_bit;

endmodule

//--- baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
  parameter int CLKS_PER_BIT = uart_cfg_pkg::CLKS_PER_BIT_DEF
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic clear,
  output logic bit_tick,
  output logic mid_tick
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(CLKS_PER_BIT / 2);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt <= '0;
    end
    else if (clear)
    begin
      cnt <= '0;
    end
    else if (run)
    begin
      if (cnt == CNT_LAST)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

  // Ticks are decoded from the count and are not masked by clear.
  assign bit_tick = run && (cnt == CNT_LAST);
  assign mid_tick = run && (cnt == CNT_MID);

endmodule

//--- uart_frame_if.sv
`timescale 1ns/1ps

interface uart_frame_if;

  // Transmit side takes a start strobe and strobes back at the end of the stop bit.
  logic                               tx_start;
  logic [uart_cfg_pkg::DATA_BITS-1:0] tx_byte;
  logic                               tx_done;

  // Receive side is armed as a level by the controller.
  logic                               rx_arm;
  logic [uart_cfg_pkg::DATA_BITS-1:0] rx_byte;
  logic                               rx_done;
  logic                               rx_perr;

  modport ctrl (
    output tx_start,
    output tx_byte,
    input  tx_done,
    output rx_arm,
    input  rx_byte,
    input  rx_done,
    input  rx_perr
  );

  modport txp (
    input  tx_start,
    input  tx_byte,
    output tx_done
  );

  modport rxp (
    input  rx_arm,
    output rx_byte,
    output rx_done,
    output rx_perr
  );

endinterface

//--- uart_cmd_pkg.sv
package uart_cmd_pkg;

  // Command word layout is write flag, 7-bit address, then the write data byte.
  parameter int CMD_WIDTH = 16;
  parameter int WRITE_BIT = 15;

  // Controller states.
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_GAP,
    ST_SEND_LO,
    ST_WAIT_RD,
    ST_DONE
  } cmd_state_e;

endpackage

//--- uart_cfg_pkg.sv
package uart_cfg_pkg;

  // 115200 baud from a 50 MHz clock.
  parameter int CLKS_PER_BIT_DEF = 434;

  // Idle bit times between the high and the low command frame.
  parameter int GAP_BITS_DEF = 2;

  // Start, eight data bits, odd parity and stop.
  parameter int FRAME_BITS = 11;

  parameter int DATA_BITS = 8;

endpackage
